// File: sim.f
hdl/bgpu_pkg.sv
hdl/wait_buffer.sv
hdl/tag_scoreboard.sv
hdl/warp_dispatcher.sv
hdl/rr_arb_tree.sv
hdl/multi_warp_dispatcher.sv
tests/tb_multi_warp_dispatcher.sv

// File: tests/tb_multi_warp_dispatcher.sv
/*
 * Testbench for the multi-warp dispatch stage
 * Stimulus table with a reference model of pending registers
 * Execution-unit model with LFSR delays and collector back-pressure
 */
`timescale 1ns/1ps

module tb_multi_warp_dispatcher;
    import bgpu_pkg::*;

    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned NUM_ROWS     = 24;
    // Cycles allowed per table row
    localparam int unsigned ROW_BUDGET   = 40;

    // One table row
    typedef struct packed {
        wid_t       warp;
        pc_t        pc;
        reg_idx_t   dst;
        reg_idx_t   src0;
        reg_idx_t   src1;
        logic [1:0] src_is_reg;
    } row_t;

    // Dispatched but not yet completed
    typedef struct packed {
        iid_t        iid;
        dec_inst_t   inst;
        logic        op_read;
        int unsigned due;
    } pend_t;

    logic       clk_i;
    logic       reset_i;
    logic       dec_valid_i;
    wid_t       dec_warp_id_i;
    dec_inst_t  dec_inst_i;
    logic       ib_ready_o;
    warp_mask_t ib_space_available_o;
    warp_mask_t ib_all_instr_finished_o;
    logic       opc_ready_i;
    logic       disp_valid_o;
    iid_t       disp_tag_o;
    dec_inst_t  disp_data_o;
    logic       opc_read_i;
    iid_t       opc_read_iid_i;
    logic       eu_valid_i;
    iid_t       eu_iid_i;

    // Reference model state
    row_t        stim [NUM_ROWS];
    int          exp_order [NUM_WARPS][$];
    pend_t       pending [$];
    int unsigned occ [NUM_WARPS];
    int unsigned tags_used [NUM_WARPS];
    logic        rd_pend;
    iid_t        rd_iid;
    logic        hold_q;
    iid_t        hold_tag;
    dec_inst_t   hold_data;
    int unsigned next_row;
    int unsigned num_dispatched;
    int unsigned cyc;
    logic [31:0] lfsr_q;

    multi_warp_dispatcher u_multi_warp_dispatcher (
        .clk_i                  ( clk_i                   ),
        .reset_i                ( reset_i                 ),
        .dec_valid_i            ( dec_valid_i             ),
        .dec_warp_id_i          ( dec_warp_id_i           ),
        .dec_inst_i             ( dec_inst_i              ),
        .ib_ready_o             ( ib_ready_o              ),
        .ib_space_available_o   ( ib_space_available_o    ),
        .ib_all_instr_finished_o( ib_all_instr_finished_o ),
        .opc_ready_i            ( opc_ready_i             ),
        .disp_valid_o           ( disp_valid_o            ),
        .disp_tag_o             ( disp_tag_o              ),
        .disp_data_o            ( disp_data_o             ),
        .opc_read_i             ( opc_read_i              ),
        .opc_read_iid_i         ( opc_read_iid_i          ),
        .eu_valid_i             ( eu_valid_i              ),
        .eu_iid_i               ( eu_iid_i                )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ####################
    // Helpers
    // ####################

    // Galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic dec_inst_t row_to_inst(input row_t r);
        dec_inst_t d;
        d.pc          = r.pc;
        d.act_mask    = '1;
        // Opcode field echoes the pc
        d.inst        = r.pc[9:2];
        d.dst         = r.dst;
        d.op_is_reg   = r.src_is_reg;
        d.operands[0] = r.src0;
        d.operands[1] = r.src1;
        return d;
    endfunction

    task automatic value_mismatch(input string name, input logic [63:0] exp_val,
                                  input logic [63:0] got_val);
        $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, got_val);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic drive_idle();
        dec_valid_i    = 1'b0;
        dec_warp_id_i  = '0;
        dec_inst_i     = '0;
        opc_ready_i    = 1'b0;
        opc_read_i     = 1'b0;
        opc_read_iid_i = '0;
        eu_valid_i     = 1'b0;
        eu_iid_i       = '0;
    endtask

    // ####################
    // Stimulus table
    // ####################

    // Each row holds warp, pc, dst, src0, src1 and source-is-register flags
    task automatic load_table();
        stim[0]  = '{2'd0, 16'h0000, 4'd1,  4'd2,  4'd3,  2'b11};
        // RAW on r1
        stim[1]  = '{2'd0, 16'h0004, 4'd4,  4'd1,  4'd1,  2'b11};
        stim[2]  = '{2'd1, 16'h1000, 4'd2,  4'd3,  4'd0,  2'b01};
        // WAW with row 0 and WAR with row 1
        stim[3]  = '{2'd0, 16'h0008, 4'd1,  4'd5,  4'd6,  2'b11};
        stim[4]  = '{2'd1, 16'h1004, 4'd3,  4'd2,  4'd2,  2'b11};
        stim[5]  = '{2'd2, 16'h2000, 4'd7,  4'd8,  4'd9,  2'b11};
        stim[6]  = '{2'd2, 16'h2004, 4'd8,  4'd7,  4'd0,  2'b01};
        // Long chain on warp 3 to fill its buffer
        stim[7]  = '{2'd3, 16'h3000, 4'd1,  4'd1,  4'd1,  2'b11};
        stim[8]  = '{2'd3, 16'h3004, 4'd1,  4'd1,  4'd0,  2'b01};
        stim[9]  = '{2'd3, 16'h3008, 4'd2,  4'd1,  4'd0,  2'b01};
        stim[10] = '{2'd3, 16'h300c, 4'd3,  4'd2,  4'd1,  2'b11};
        stim[11] = '{2'd3, 16'h3010, 4'd4,  4'd3,  4'd0,  2'b00};
        stim[12] = '{2'd3, 16'h3014, 4'd5,  4'd4,  4'd3,  2'b11};
        stim[13] = '{2'd1, 16'h1008, 4'd9,  4'd10, 4'd11, 2'b11};
        stim[14] = '{2'd0, 16'h000c, 4'd6,  4'd4,  4'd1,  2'b11};
        stim[15] = '{2'd2, 16'h2008, 4'd9,  4'd8,  4'd7,  2'b11};
        stim[16] = '{2'd1, 16'h100c, 4'd2,  4'd9,  4'd0,  2'b01};
        stim[17] = '{2'd0, 16'h0010, 4'd2,  4'd6,  4'd0,  2'b01};
        stim[18] = '{2'd2, 16'h200c, 4'd7,  4'd9,  4'd9,  2'b11};
        stim[19] = '{2'd1, 16'h1010, 4'd10, 4'd2,  4'd3,  2'b11};
        stim[20] = '{2'd0, 16'h0014, 4'd3,  4'd0,  4'd0,  2'b00};
        stim[21] = '{2'd2, 16'h2010, 4'd11, 4'd7,  4'd8,  2'b11};
        stim[22] = '{2'd3, 16'h3018, 4'd6,  4'd5,  4'd5,  2'b11};
        stim[23] = '{2'd0, 16'h0018, 4'd7,  4'd3,  4'd2,  2'b11};
    endtask

    // ####################
    // Checks
    // ####################

    // Room per warp is a free tag and a free slot
    task automatic check_levels();
        warp_mask_t exp_space;
        warp_mask_t exp_done;
        for (int w = 0; w < NUM_WARPS; w++) begin
            exp_space[w] = (occ[w] < WAIT_BUF_DEPTH) && (tags_used[w] < NUM_TAGS);
            exp_done[w]  = (tags_used[w] == 0);
        end
        assert (ib_space_available_o == exp_space)
            else value_mismatch("ib_space_available_o", exp_space, ib_space_available_o);
        assert (ib_all_instr_finished_o == exp_done)
            else value_mismatch("ib_all_instr_finished_o", exp_done, ib_all_instr_finished_o);
        assert (ib_ready_o == exp_space[dec_warp_id_i])
            else value_mismatch("ib_ready_o", exp_space[dec_warp_id_i], ib_ready_o);
    endtask

    // Offer stalled by the collector must not move
    task automatic check_hold();
        if (hold_q) begin
            assert (disp_valid_o) else fail_plain("disp_valid_o dropped under back-pressure");
            assert (disp_tag_o == hold_tag)
                else value_mismatch("disp_tag_o", hold_tag, disp_tag_o);
            assert (disp_data_o == hold_data)
                else value_mismatch("disp_data_o", hold_data, disp_data_o);
        end
    endtask

    // Order, tag use and register hazards of one dispatch
    task automatic check_dispatch();
        wid_t      w;
        dec_inst_t d;
        dec_inst_t exp_inst;
        int        in_flight;
        w         = disp_tag_o[WID_WIDTH-1:0];
        d         = disp_data_o;
        in_flight = 0;
        assert (exp_order[w].size() > 0) else fail_plain("dispatch from a warp with no rows left");
        exp_inst = row_to_inst(stim[exp_order[w][0]]);
        assert (d == exp_inst) else value_mismatch("disp_data_o", exp_inst, d);
        foreach (pending[k]) begin
            if (pending[k].iid[WID_WIDTH-1:0] == w) begin
                in_flight++;
                assert (pending[k].iid != disp_tag_o)
                    else fail_plain("disp_tag_o reused while still in flight");
                assert (d.dst != pending[k].inst.dst)
                    else fail_plain("write-after-write hazard was dispatched");
                for (int j = 0; j < OPS_PER_INST; j++) begin
                    assert (!(d.op_is_reg[j] && d.operands[j] == pending[k].inst.dst))
                        else fail_plain("read-after-write hazard was dispatched");
                    // Operands of a read entry no longer matter
                    assert (pending[k].op_read || !(pending[k].inst.op_is_reg[j] &&
                            pending[k].inst.operands[j] == d.dst))
                        else fail_plain("write-after-read hazard was dispatched");
                end
            end
        end
        assert (in_flight < NUM_TAGS) else fail_plain("warp holds more instructions than tags");
        void'(exp_order[w].pop_front());
    endtask

    // ####################
    // Main sequence
    // ####################

    initial begin
        logic [31:0] rnd;
        int          eu_idx;
        logic        acc;
        logic        disp;
        wid_t        w;
        pend_t       entry;
        load_table();
        lfsr_q         = 32'h42a1_a5c5;
        rd_pend        = 1'b0;
        rd_iid         = '0;
        hold_q         = 1'b0;
        hold_tag       = '0;
        hold_data      = '0;
        next_row       = 0;
        num_dispatched = 0;
        cyc            = 0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            occ[i]       = 0;
            tags_used[i] = 0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_order[stim[r].warp].push_back(r);
        end
        clk_i   = 1'b0;
        reset_i = 1'b1;
        drive_idle();

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        // Idle state straight out of reset
        assert (!disp_valid_o) else value_mismatch("disp_valid_o", 1'b0, disp_valid_o);
        assert (ib_ready_o) else value_mismatch("ib_ready_o", 1'b1, ib_ready_o);
        check_levels();

        while (!(next_row == NUM_ROWS && num_dispatched == NUM_ROWS &&
                 pending.size() == 0 && !rd_pend)) begin
            @(negedge clk_i);
            // Decoder offers the next row until accepted
            if (next_row < NUM_ROWS) begin
                dec_valid_i   = 1'b1;
                dec_warp_id_i = stim[next_row].warp;
                dec_inst_i    = row_to_inst(stim[next_row]);
            end else begin
                dec_valid_i = 1'b0;
            end
            // Collector stalls about one cycle in four
            draw_bits(2, rnd);
            opc_ready_i    = (rnd[1:0] != 2'b00);
            opc_read_i     = rd_pend;
            opc_read_iid_i = rd_iid;
            // Oldest read entry that is due completes
            eu_idx = -1;
            foreach (pending[k]) begin
                if (eu_idx < 0 && pending[k].op_read && pending[k].due <= cyc) begin
                    eu_idx = k;
                end
            end
            eu_valid_i = (eu_idx >= 0);
            eu_iid_i   = (eu_idx >= 0) ? pending[eu_idx].iid : '0;
            #1;
            check_levels();
            check_hold();

            // Handshakes of the coming edge
            acc  = dec_valid_i && ib_ready_o;
            disp = disp_valid_o && opc_ready_i;
            if (disp) begin
                check_dispatch();
            end
            if (eu_valid_i) begin
                w = eu_iid_i[WID_WIDTH-1:0];
                tags_used[w]--;
                pending.delete(eu_idx);
            end
            if (opc_read_i) begin
                foreach (pending[k]) begin
                    if (pending[k].iid == opc_read_iid_i) begin
                        pending[k].op_read = 1'b1;
                    end
                end
            end
            // Read notice one cycle after dispatch
            rd_pend = disp;
            rd_iid  = disp_tag_o;
            if (disp) begin
                // Completion 1 to 8 cycles after the read
                draw_bits(3, rnd);
                w             = disp_tag_o[WID_WIDTH-1:0];
                entry.iid     = disp_tag_o;
                entry.inst    = disp_data_o;
                entry.op_read = 1'b0;
                entry.due     = cyc + 2 + rnd[2:0];
                pending.push_back(entry);
                occ[w]--;
                num_dispatched++;
            end
            if (acc) begin
                occ[dec_warp_id_i]++;
                tags_used[dec_warp_id_i]++;
                next_row++;
            end
            hold_q    = disp_valid_o && !opc_ready_i;
            hold_tag  = disp_tag_o;
            hold_data = disp_data_o;
            cyc++;
        end

        // Drained with all tags back and nothing offered
        @(negedge clk_i);
        drive_idle();
        #1;
        check_levels();
        assert (ib_all_instr_finished_o == '1)
            else value_mismatch("ib_all_instr_finished_o", warp_mask_t'('1),
                                ib_all_instr_finished_o);
        assert (!disp_valid_o) else value_mismatch("disp_valid_o", 1'b0, disp_valid_o);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #((RESET_CYCLES + NUM_ROWS * ROW_BUDGET) * CLK_PERIOD);
        $display("Error: watchdog expired, the dispatch stage did not drain in time");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

endmodule : tb_multi_warp_dispatcher

// File: hdl/multi_warp_dispatcher.sv
/*
 * Dispatch stage top level
 * Per-warp strobe routing, one dispatcher per warp
 * Round-robin arbitration toward the operand collector
 */
`timescale 1ns/1ps

module multi_warp_dispatcher (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 dec_valid_i,
    input  bgpu_pkg::wid_t       dec_warp_id_i,
    input  bgpu_pkg::dec_inst_t  dec_inst_i,
    output logic                 ib_ready_o,
    output bgpu_pkg::warp_mask_t ib_space_available_o,
    output bgpu_pkg::warp_mask_t ib_all_instr_finished_o,
    input  logic                 opc_ready_i,
    output logic                 disp_valid_o,
    output bgpu_pkg::iid_t       disp_tag_o,
    output bgpu_pkg::dec_inst_t  disp_data_o,
    input  logic                 opc_read_i,
    input  bgpu_pkg::iid_t       opc_read_iid_i,
    input  logic                 eu_valid_i,
    input  bgpu_pkg::iid_t       eu_iid_i
);
    import bgpu_pkg::*;

    // Per-warp strobes and levels
    warp_mask_t dec_valid_warp;
    warp_mask_t ready_warp;
    warp_mask_t opc_read_warp;
    warp_mask_t eu_valid_warp;
    warp_mask_t disp_valid_warp;
    warp_mask_t arb_gnt;

    // Arbiter payload
    disp_data_t arb_in_data [NUM_WARPS];
    disp_data_t arb_sel_data;
    wid_t       arb_sel_wid;

    // ####################
    // Strobe routing
    // ####################

    // Decode beat to the addressed warp only
    always_comb begin
        dec_valid_warp                = '0;
        dec_valid_warp[dec_warp_id_i] = dec_valid_i;
    end

    assign ib_ready_o = ready_warp[dec_warp_id_i];

    // Warp ID sits in the low bits of an iid
    always_comb begin
        opc_read_warp                                = '0;
        opc_read_warp[opc_read_iid_i[WID_WIDTH-1:0]] = opc_read_i;
        eu_valid_warp                                = '0;
        eu_valid_warp[eu_iid_i[WID_WIDTH-1:0]]       = eu_valid_i;
    end

    // ####################
    // Dispatchers
    // ####################

    for (genvar w = 0; w < NUM_WARPS; w++) begin : gen_warp
        warp_dispatcher i_warp_dispatcher (
            .clk_i            ( clk_i                                  ),
            .reset_i          ( reset_i                                ),
            .dec_valid_i      ( dec_valid_warp[w]                      ),
            .dec_inst_i       ( dec_inst_i                             ),
            .ready_o          ( ready_warp[w]                          ),
            .space_available_o( ib_space_available_o[w]                ),
            .all_finished_o   ( ib_all_instr_finished_o[w]             ),
            .disp_valid_o     ( disp_valid_warp[w]                     ),
            .disp_data_o      ( arb_in_data[w]                         ),
            .grant_i          ( arb_gnt[w]                             ),
            .opc_read_i       ( opc_read_warp[w]                       ),
            .opc_read_tag_i   ( opc_read_iid_i[WID_WIDTH +: TAG_WIDTH] ),
            .eu_valid_i       ( eu_valid_warp[w]                       ),
            .eu_tag_i         ( eu_iid_i[WID_WIDTH +: TAG_WIDTH]       )
        );
    end : gen_warp

    // ####################
    // Arbitration
    // ####################

    // Grant to a warp already includes the collector's ready
    rr_arb_tree #(
        .data_t( disp_data_t ),
        .num_in( NUM_WARPS   )
    ) i_rr_arb (
        .clk_i  ( clk_i           ),
        .reset_i( reset_i         ),
        .req_i  ( disp_valid_warp ),
        .data_i ( arb_in_data     ),
        .gnt_o  ( arb_gnt         ),
        .req_o  ( disp_valid_o    ),
        .data_o ( arb_sel_data    ),
        .idx_o  ( arb_sel_wid     ),
        .gnt_i  ( opc_ready_i     )
    );

    // Global ID is the tag above the warp
    assign disp_tag_o  = {arb_sel_data.tag, arb_sel_wid};
    assign disp_data_o = arb_sel_data.dec;

endmodule : multi_warp_dispatcher

// File: hdl/rr_arb_tree.sv
/*
 * Fair round-robin arbiter with typed payload
 * Selection is held while the sink is not ready
 */
`timescale 1ns/1ps

module rr_arb_tree #(
    parameter type         data_t    = logic,
    parameter int unsigned num_in    = 2,
    parameter int unsigned idx_width = (num_in > 1) ? $clog2(num_in) : 1
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [num_in-1:0]    req_i,
    input  data_t                data_i [num_in],
    output logic [num_in-1:0]    gnt_o,
    output logic                 req_o,
    output data_t                data_o,
    output logic [idx_width-1:0] idx_o,
    input  logic                 gnt_i
);
    // Round-robin start point
    logic [idx_width-1:0] ptr_q;
    // Held selection under back-pressure
    logic                 lock_q;
    logic [idx_width-1:0] lock_idx_q;
    logic [idx_width-1:0] rr_idx;

    // First requester at or above the pointer with wrap-around
    always_comb begin
        int unsigned cand;
        logic        found;
        found  = 1'b0;
        rr_idx = '0;
        for (int unsigned i = 0; i < num_in; i++) begin
            cand = (int'(ptr_q) + i) % num_in;
            if (!found && req_i[cand]) begin
                found  = 1'b1;
                rr_idx = idx_width'(cand);
            end
        end
    end

    assign req_o  = |req_i;
    assign idx_o  = lock_q ? lock_idx_q : rr_idx;
    assign data_o = data_i[idx_o];

    always_comb begin
        gnt_o        = '0;
        gnt_o[idx_o] = req_o && gnt_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (req_o && gnt_i) begin
            // Winner goes to the back of the line
            ptr_q  <= (idx_o == num_in - 1) ? '0 : idx_o + 1'b1;
            lock_q <= 1'b0;
        end else if (req_o) begin
            lock_q     <= 1'b1;
            lock_idx_q <= idx_o;
        end
    end

    // Grant is one-hot and lands on an active requester
    assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
        else $error("arbiter grant is not one-hot to a requester");

endmodule : rr_arb_tree

// File: hdl/warp_dispatcher.sv
/*
 * Dispatcher of one warp
 * Accept control, wait buffer and scoreboard hold-back
 */
`timescale 1ns/1ps

module warp_dispatcher (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 dec_valid_i,
    input  bgpu_pkg::dec_inst_t  dec_inst_i,
    output logic                 ready_o,
    output logic                 space_available_o,
    output logic                 all_finished_o,
    output logic                 disp_valid_o,
    output bgpu_pkg::disp_data_t disp_data_o,
    input  logic                 grant_i,
    input  logic                 opc_read_i,
    input  bgpu_pkg::tag_t       opc_read_tag_i,
    input  logic                 eu_valid_i,
    input  bgpu_pkg::tag_t       eu_tag_i
);
    import bgpu_pkg::*;

    logic       accept;
    logic       buf_full;
    logic       tag_free;
    logic       head_valid;
    logic       hazard;
    tag_t       alloc_tag;
    disp_data_t push_data;
    disp_data_t head_data;

    // Room means a free tag and a free slot
    assign ready_o           = !buf_full && tag_free;
    assign space_available_o = ready_o;
    assign accept            = dec_valid_i && ready_o;

    // Tag joins the instruction on its way in
    assign push_data.tag = alloc_tag;
    assign push_data.dec = dec_inst_i;

    // Head leaves only once its registers are clear
    assign disp_valid_o = head_valid && !hazard;
    assign disp_data_o  = head_data;

    wait_buffer i_wait_buffer (
        .clk_i       ( clk_i      ),
        .reset_i     ( reset_i    ),
        .push_i      ( accept     ),
        .push_data_i ( push_data  ),
        .full_o      ( buf_full   ),
        .pop_i       ( grant_i    ),
        .head_valid_o( head_valid ),
        .head_data_o ( head_data  )
    );

    tag_scoreboard i_tag_scoreboard (
        .clk_i         ( clk_i          ),
        .reset_i       ( reset_i        ),
        .alloc_i       ( accept         ),
        .alloc_tag_o   ( alloc_tag      ),
        .tag_free_o    ( tag_free       ),
        .head_inst_i   ( head_data.dec  ),
        .head_tag_i    ( head_data.tag  ),
        .issue_i       ( grant_i        ),
        .hazard_o      ( hazard         ),
        .read_i        ( opc_read_i     ),
        .read_tag_i    ( opc_read_tag_i ),
        .done_i        ( eu_valid_i     ),
        .done_tag_i    ( eu_tag_i       ),
        .all_finished_o( all_finished_o )
    );

    // An offered head stays put until granted
    assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o && !grant_i |=> disp_valid_o && $stable(disp_data_o))
        else $error("dispatch offer withdrawn or changed before grant");

endmodule : warp_dispatcher

// File: hdl/tag_scoreboard.sv
/*
 * Per-warp tag allocator and register scoreboard
 * Hazard check of the buffer head against issued tags
 */
`timescale 1ns/1ps

module tag_scoreboard (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                alloc_i,
    output bgpu_pkg::tag_t      alloc_tag_o,
    output logic                tag_free_o,
    input  bgpu_pkg::dec_inst_t head_inst_i,
    input  bgpu_pkg::tag_t      head_tag_i,
    input  logic                issue_i,
    output logic                hazard_o,
    input  logic                read_i,
    input  bgpu_pkg::tag_t      read_tag_i,
    input  logic                done_i,
    input  bgpu_pkg::tag_t      done_tag_i,
    output logic                all_finished_o
);
    import bgpu_pkg::*;

    // Life cycle of one tag
    typedef enum logic [1:0] {
        TAG_FREE,
        TAG_ALLOC,
        TAG_ISSUED,
        TAG_READ
    } tag_state_e;

    tag_state_e state_q [NUM_TAGS];

    // Register record, written at issue
    reg_idx_t                    dst_q       [NUM_TAGS];
    logic [OPS_PER_INST-1:0]     op_is_reg_q [NUM_TAGS];
    reg_idx_t [OPS_PER_INST-1:0] ops_q       [NUM_TAGS];

    // ####################
    // Allocation
    // ####################

    // Lowest free tag wins, scan from the top
    always_comb begin
        tag_free_o  = 1'b0;
        alloc_tag_o = '0;
        for (int t = NUM_TAGS - 1; t >= 0; t--) begin
            if (state_q[t] == TAG_FREE) begin
                tag_free_o  = 1'b1;
                alloc_tag_o = tag_t'(t);
            end
        end
    end

    always_comb begin
        all_finished_o = 1'b1;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (state_q[t] != TAG_FREE) begin
                all_finished_o = 1'b0;
            end
        end
    end

    // ####################
    // Hazard check
    // ####################

    always_comb begin
        hazard_o = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            // Result of this tag still pending
            if (state_q[t] == TAG_ISSUED || state_q[t] == TAG_READ) begin
                // WAW
                if (head_inst_i.dst == dst_q[t]) begin
                    hazard_o = 1'b1;
                end
                // RAW on any register source
                for (int j = 0; j < OPS_PER_INST; j++) begin
                    if (head_inst_i.op_is_reg[j] && head_inst_i.operands[j] == dst_q[t]) begin
                        hazard_o = 1'b1;
                    end
                end
            end
            // WAR until the operand collector has read
            if (state_q[t] == TAG_ISSUED) begin
                for (int j = 0; j < OPS_PER_INST; j++) begin
                    if (op_is_reg_q[t][j] && ops_q[t][j] == head_inst_i.dst) begin
                        hazard_o = 1'b1;
                    end
                end
            end
        end
    end

    // ####################
    // State update
    // ####################

    // Later statements win, so completion beats a same-cycle read
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                state_q[t] <= TAG_FREE;
            end
        end else begin
            if (alloc_i) begin
                state_q[alloc_tag_o] <= TAG_ALLOC;
            end
            if (issue_i) begin
                state_q[head_tag_i] <= TAG_ISSUED;
            end
            if (read_i) begin
                state_q[read_tag_i] <= TAG_READ;
            end
            if (done_i) begin
                state_q[done_tag_i] <= TAG_FREE;
            end
        end
    end

    // Capture registers of the issuing head
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            dst_q[head_tag_i]       <= head_inst_i.dst;
            op_is_reg_q[head_tag_i] <= head_inst_i.op_is_reg;
            ops_q[head_tag_i]       <= head_inst_i.operands;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        done_i |-> state_q[done_tag_i] inside {TAG_ISSUED, TAG_READ})
        else $error("completion for a tag that was never issued");
    assert property (@(posedge clk_i) disable iff (reset_i)
        read_i |-> state_q[read_tag_i] == TAG_ISSUED)
        else $error("operand read for a tag that is not issued");
    assert property (@(posedge clk_i) disable iff (reset_i) alloc_i |-> tag_free_o)
        else $error("tag allocated with none free");

endmodule : tag_scoreboard

// File: hdl/wait_buffer.sv
/*
 * Per-warp wait buffer
 * Circular FIFO of tagged instructions, head shown combinationally
 */
`timescale 1ns/1ps

module wait_buffer (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 push_i,
    input  bgpu_pkg::disp_data_t push_data_i,
    output logic                 full_o,
    input  logic                 pop_i,
    output logic                 head_valid_o,
    output bgpu_pkg::disp_data_t head_data_o
);
    import bgpu_pkg::*;

    // Entry storage
    disp_data_t mem_q [WAIT_BUF_DEPTH];

    logic [$clog2(WAIT_BUF_DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(WAIT_BUF_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(WAIT_BUF_DEPTH+1)-1:0] count_q;

    // Status from the fill count
    assign full_o       = (count_q == WAIT_BUF_DEPTH);
    assign head_valid_o = (count_q != '0);
    // Oldest entry without a register stage
    assign head_data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap at the last entry
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == WAIT_BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == WAIT_BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Ready upstream must already exclude a full buffer
    assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full_o)
        else $error("wait buffer pushed while full");
    // Grant only reaches a warp with a valid head
    assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> head_valid_o)
        else $error("wait buffer popped while empty");

endmodule : wait_buffer

// File: hdl/bgpu_pkg.sv
/*
 * Dispatch-stage sizes and scalar types
 * Decoded instruction struct and tagged dispatch struct
 */
package bgpu_pkg;

    // ####################
    // Sizes
    // ####################

    // Warps per compute unit
    localparam int unsigned NUM_WARPS      = 4;
    // In-flight instructions per warp
    localparam int unsigned NUM_TAGS       = 4;
    // Buffered instructions per warp
    localparam int unsigned WAIT_BUF_DEPTH = 4;
    localparam int unsigned PC_WIDTH       = 16;
    // Threads per warp
    localparam int unsigned WARP_WIDTH     = 8;
    localparam int unsigned REG_IDX_WIDTH  = 4;
    localparam int unsigned OPS_PER_INST   = 2;
    // Opcode width
    localparam int unsigned INST_WIDTH     = 8;
    localparam int unsigned WID_WIDTH      = $clog2(NUM_WARPS);
    localparam int unsigned TAG_WIDTH      = $clog2(NUM_TAGS);

    // ####################
    // Types
    // ####################

    typedef logic [WID_WIDTH-1:0]           wid_t;
    typedef logic [TAG_WIDTH-1:0]           tag_t;
    // Tag sits above the warp ID
    typedef logic [TAG_WIDTH+WID_WIDTH-1:0] iid_t;
    typedef logic [PC_WIDTH-1:0]            pc_t;
    typedef logic [WARP_WIDTH-1:0]          act_mask_t;
    typedef logic [REG_IDX_WIDTH-1:0]       reg_idx_t;
    typedef logic [INST_WIDTH-1:0]          inst_t;
    typedef logic [NUM_WARPS-1:0]           warp_mask_t;

    // Instruction as delivered by the decoder
    typedef struct packed {
        pc_t                         pc;
        act_mask_t                   act_mask;
        inst_t                       inst;
        reg_idx_t                    dst;
        logic [OPS_PER_INST-1:0]     op_is_reg;
        reg_idx_t [OPS_PER_INST-1:0] operands;
    } dec_inst_t;

    // Buffered instruction with its in-flight tag
    typedef struct packed {
        tag_t      tag;
        dec_inst_t dec;
    } disp_data_t;

endpackage : bgpu_pkg
